// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module vendingTb -f project.f --Mdir build -o vendingSim
	./build/vendingSim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf build sim.log

// ==== logic/creditController.sv ====
`include "vending_cfg.svh"

module creditController (
    input  logic                A1,
    input  logic                A2,
    input  vendPkg::itemKeysT   itemPulse,
    input  vendPkg::coinKeysT   coinPulse,
    input  logic                cancelPulse,
    output vendPkg::itemKeysT   ledGreen,           // slot affordable
    output vendPkg::itemKeysT   ledRed,             // slot sold out
    output vendPkg::itemKeysT   ledDispensed,       // last slot sold
    output vendPkg::displayReqT displayReq
);

    localparam vendPkg::moneyT priceTable [`ITEM_COUNT] = '{
        vendPkg::moneyT'(`ITEM_PRICE_0),
        vendPkg::moneyT'(`ITEM_PRICE_1),
        vendPkg::moneyT'(`ITEM_PRICE_2),
        vendPkg::moneyT'(`ITEM_PRICE_3),
        vendPkg::moneyT'(`ITEM_PRICE_4),
        vendPkg::moneyT'(`ITEM_PRICE_5),
        vendPkg::moneyT'(`ITEM_PRICE_6),
        vendPkg::moneyT'(`ITEM_PRICE_7),
        vendPkg::moneyT'(`ITEM_PRICE_8)
    };

    localparam vendPkg::moneyT coinTable [`COIN_COUNT] = '{
        vendPkg::moneyT'(`COIN_VALUE_0),
        vendPkg::moneyT'(`COIN_VALUE_1),
        vendPkg::moneyT'(`COIN_VALUE_2),
        vendPkg::moneyT'(`COIN_VALUE_3),
        vendPkg::moneyT'(`COIN_VALUE_4),
        vendPkg::moneyT'(`COIN_VALUE_5)
    };

    localparam vendPkg::moneyT creditCeiling = vendPkg::moneyT'(`MAX_CREDIT);

    function automatic vendPkg::itemKeysT soldOutMask();
        vendPkg::itemKeysT mask;
        mask = '0;
        for (int i = 0; i < `ITEM_COUNT; i++) begin
            mask[i] = (priceTable[i] == '0);
        end
        return mask;
    endfunction

    localparam vendPkg::itemKeysT soldOut = soldOutMask();

    vendPkg::moneyT      credit;
    vendPkg::moneyT      creditNext;
    vendPkg::moneyT      coinValue;                 // value of the winning coin
    vendPkg::moneyT      itemPrice;                 // price of the winning slot
    vendPkg::itemKeysT   itemHot;                   // winning slot as one hot
    vendPkg::itemKeysT   dispensedNext;
    vendPkg::itemKeysT   greenNext;
    vendPkg::displayReqT reqNext;
    logic [`MONEY_BITS:0] coinSum;                  // one spare bit for the ceiling test

    assign ledRed  = soldOut;                       // prices are fixed in this build
    assign coinSum = {1'b0, credit} + {1'b0, coinValue};

    // pick the lowest set index in each bank
    always_comb begin
        coinValue = '0;
        itemPrice = '0;
        itemHot   = '0;
        for (int i = `COIN_COUNT - 1; i >= 0; i--) begin
            if (coinPulse[i]) coinValue = coinTable[i];
        end
        for (int i = `ITEM_COUNT - 1; i >= 0; i--) begin
            if (itemPulse[i]) begin
                itemPrice = priceTable[i];
                itemHot   = vendPkg::itemKeysT'(1) << i;
            end
        end
    end

    always_comb begin
        creditNext    = credit;
        dispensedNext = ledDispensed;
        reqNext       = displayReq;
        if (cancelPulse) begin                                      // cancel beats everything
            creditNext    = '0;
            dispensedNext = '0;
            reqNext       = '0;
        end else if (|coinPulse) begin
            if (coinSum <= {1'b0, creditCeiling}) begin             // refused coin is ignored
                creditNext = coinSum[`MONEY_BITS-1:0];
                reqNext    = '{negative: 1'b0, magnitude: coinSum[`MONEY_BITS-1:0]};
            end
        end else if (|itemPulse) begin
            if (credit == '0) begin
                reqNext = '{negative: 1'b0, magnitude: itemPrice};  // price query
            end else if (itemPrice != '0 && credit >= itemPrice) begin
                reqNext       = '{negative: 1'b0, magnitude: credit - itemPrice};
                dispensedNext = itemHot;
                creditNext    = '0;                                 // sale closes the credit
            end else if (itemPrice == '0) begin
                reqNext = '{negative: 1'b1, magnitude: credit};     // sold out slot
            end else begin
                reqNext = '{negative: 1'b1, magnitude: itemPrice - credit}; // shortfall
            end
        end
        for (int i = 0; i < `ITEM_COUNT; i++) begin
            greenNext[i] = (priceTable[i] != '0) && (creditNext >= priceTable[i]);
        end
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            credit       <= '0;
            ledDispensed <= '0;
            ledGreen     <= '0;
            displayReq   <= '0;
        end else begin
            credit       <= creditNext;
            ledDispensed <= dispensedNext;
            ledGreen     <= greenNext;
            displayReq   <= reqNext;
        end
    end

    creditCap: assert property (@(posedge A1) disable iff (A2) credit <= creditCeiling);

endmodule

// ==== logic/displayFormatter.sv ====
`include "vending_cfg.svh"

module displayFormatter (
    input  logic                A1,
    input  logic                A2,
    input  vendPkg::displayReqT displayReq,
    output segPkg::digitSegsT   digits
);

    localparam segPkg::segmentT dotMask = 8'hFE;    // clears bit 0 to light the point

    vendPkg::moneyT belowDollar;                    // cents left after whole dollars
    logic [3:0]     dollars;
    logic [3:0]     tens;
    logic [3:0]     cents;

    function automatic segPkg::segmentT glyph(input logic [3:0] value);
        segPkg::segmentT pattern;
        case (value)
            4'd0:    pattern = `SEG_DIGIT_0;
            4'd1:    pattern = `SEG_DIGIT_1;
            4'd2:    pattern = `SEG_DIGIT_2;
            4'd3:    pattern = `SEG_DIGIT_3;
            4'd4:    pattern = `SEG_DIGIT_4;
            4'd5:    pattern = `SEG_DIGIT_5;
            4'd6:    pattern = `SEG_DIGIT_6;
            4'd7:    pattern = `SEG_DIGIT_7;
            4'd8:    pattern = `SEG_DIGIT_8;
            4'd9:    pattern = `SEG_DIGIT_9;
            default: pattern = 8'hFF;               // blank
        endcase
        return pattern;
    endfunction

    // decimal split of the magnitude
    always_comb begin
        dollars     = 4'(displayReq.magnitude / vendPkg::moneyT'(100));
        belowDollar = displayReq.magnitude % vendPkg::moneyT'(100);
        tens        = 4'(belowDollar / vendPkg::moneyT'(10));
        cents       = 4'(belowDollar % vendPkg::moneyT'(10));
    end

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            digits[3] <= `SEG_DIGIT_0;              // reads 0.00 out of reset
            digits[2] <= `SEG_DIGIT_0 & dotMask;
            digits[1] <= `SEG_DIGIT_0;
            digits[0] <= `SEG_DIGIT_0;
        end else begin
            digits[3] <= displayReq.negative ? `SEG_MINUS : `SEG_DIGIT_0;
            digits[2] <= glyph(dollars) & dotMask;  // dollars carry the point
            digits[1] <= glyph(tens);
            digits[0] <= glyph(cents);
        end
    end

    // three digits only hold up to 9.99 and the controller stays far below
    magnitudeRange: assert property (@(posedge A1) disable iff (A2)
        displayReq.magnitude <= vendPkg::moneyT'(`MAX_CREDIT));

endmodule

// ==== logic/displayScanner.sv ====
`include "vending_cfg.svh"

module displayScanner (
    input  logic              A1,
    input  logic              A2,
    input  segPkg::digitSegsT digits,
    output segPkg::anodeT     anode,
    output segPkg::segmentT   segments
);

    localparam int cntBits = `SCAN_DIV_BITS + 2;    // two extra bits pick the digit

    logic [cntBits-1:0] refreshCnt;                 // free running
    logic [1:0]         digitSel;

    assign digitSel = refreshCnt[cntBits-1 -: 2];

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            refreshCnt <= '0;
            anode      <= 4'b1110;                  // rightmost digit first
            segments   <= 8'hFF;                    // dark until the first scan
        end else begin
            refreshCnt <= refreshCnt + 1'b1;
            anode      <= ~(segPkg::anodeT'(1) << digitSel);
            segments   <= digits[digitSel];
        end
    end

    // two enabled anodes would ghost one digit onto another
    oneAnode: assert property (@(posedge A1) disable iff (A2) $onehot(~anode));

endmodule

// ==== logic/keyBank.sv ====
`include "vending_cfg.svh"

module keyBank #(
    parameter type keyT = logic                 // vector of keys handled together
) (
    input  logic A1,
    input  logic A2,
    input  keyT  keys_n,                        // raw buttons pulled up
    output keyT  pulses                         // one cycle per accepted press
);

    localparam int keyBits = $bits(keyT);
    localparam int cntBits = $clog2(`DEBOUNCE_CYCLES + 1);

    logic [keyBits-1:0] rawPressed;             // high while a key is held
    logic [keyBits-1:0] syncFirst;              // first synchronizer stage
    logic [keyBits-1:0] syncSecond;             // second synchronizer stage
    logic [keyBits-1:0] level;                  // accepted debounced level
    logic [keyBits-1:0] pulseVec;
    logic [cntBits-1:0] stableCnt [keyBits];    // run of samples unlike level

    assign rawPressed = ~keys_n;
    assign pulses     = keyT'(pulseVec);

    always_ff @(posedge A1 or posedge A2) begin
        if (A2) begin
            syncFirst  <= '0;
            syncSecond <= '0;
            level      <= '0;
            pulseVec   <= '0;
            for (int i = 0; i < keyBits; i++) begin
                stableCnt[i] <= '0;
            end
        end else begin
            syncFirst  <= rawPressed;
            syncSecond <= syncFirst;
            for (int i = 0; i < keyBits; i++) begin
                pulseVec[i] <= 1'b0;                                // pulse lasts one cycle
                if (syncSecond[i] == level[i]) begin
                    stableCnt[i] <= '0;                             // bounce restarts the run
                end else if (stableCnt[i] == cntBits'(`DEBOUNCE_CYCLES - 1)) begin
                    stableCnt[i] <= '0;
                    level[i]     <= syncSecond[i];                  // new level accepted
                    pulseVec[i]  <= syncSecond[i];                  // only on press not release
                end else begin
                    stableCnt[i] <= stableCnt[i] + 1'b1;
                end
            end
        end
    end

    pulseSingle: assert property (@(posedge A1) disable iff (A2)
        (pulseVec & $past(pulseVec)) == '0);

endmodule

// ==== logic/segPkg.sv ====
package segPkg;

    // one digit pattern
    // active low with the decimal point in bit 0
    typedef logic [7:0] segmentT;

    // all four digits of the display
    // index 3 is the leftmost digit
    typedef segmentT [3:0] digitSegsT;

    // common anode enables
    typedef logic [3:0] anodeT;                 // active low with one digit lit at a time

endpackage

// ==== logic/vendPkg.sv ====
`include "vending_cfg.svh"

package vendPkg;

    // amounts of money in cents
    typedef logic [`MONEY_BITS-1:0] moneyT;     // covers prices change and credit

    // one bit per slot and per coin kind
    typedef logic [`ITEM_COUNT-1:0] itemKeysT;  // bit 0 is the first slot
    typedef logic [`COIN_COUNT-1:0] coinKeysT;  // bit 0 is the nickel

    // what the controller wants on the display
    // the formatter turns it into digit patterns
    typedef struct packed {
        logic  negative;                        // draws a minus on the left digit
        moneyT magnitude;                       // cents shown as d.dd
    } displayReqT;

endpackage

// ==== logic/vendingTop.sv ====
`include "vending_cfg.svh"

module vendingTop (
    input  logic                   A1,
    input  logic                   A2,
    input  logic [`ITEM_COUNT-1:0] itemKey_n,       // slot buttons pulled up
    input  logic [`COIN_COUNT-1:0] coinKey_n,       // coin sensors pulled up
    input  logic                   cancelKey_n,
    output logic [`ITEM_COUNT-1:0] ledGreen,
    output logic [`ITEM_COUNT-1:0] ledRed,
    output logic [`ITEM_COUNT-1:0] ledDispensed,
    output logic [3:0]             anode,
    output logic [7:0]             segments
);

    vendPkg::itemKeysT   itemPulse;
    vendPkg::coinKeysT   coinPulse;
    logic                cancelPulse;
    vendPkg::displayReqT displayReq;               // held until the next event
    segPkg::digitSegsT   digits;

    keyBank #(.keyT(vendPkg::itemKeysT)) itemKeys (
        .A1     (A1),
        .A2     (A2),
        .keys_n (itemKey_n),
        .pulses (itemPulse)
    );

    keyBank #(.keyT(vendPkg::coinKeysT)) coinKeys (
        .A1     (A1),
        .A2     (A2),
        .keys_n (coinKey_n),
        .pulses (coinPulse)
    );

    keyBank #(.keyT(logic)) cancelKey (
        .A1     (A1),
        .A2     (A2),
        .keys_n (cancelKey_n),
        .pulses (cancelPulse)
    );

    creditController credit (
        .A1           (A1),
        .A2           (A2),
        .itemPulse    (itemPulse),
        .coinPulse    (coinPulse),
        .cancelPulse  (cancelPulse),
        .ledGreen     (ledGreen),
        .ledRed       (ledRed),
        .ledDispensed (ledDispensed),
        .displayReq   (displayReq)
    );

    displayFormatter formatter (
        .A1         (A1),
        .A2         (A2),
        .displayReq (displayReq),
        .digits     (digits)
    );

    displayScanner scanner (
        .A1       (A1),
        .A2       (A2),
        .digits   (digits),
        .anode    (anode),
        .segments (segments)
    );

endmodule

// ==== logic/vending_cfg.svh ====
`ifndef VENDING_CFG_SVH
`define VENDING_CFG_SVH

`define ITEM_COUNT      9           // slots on the front panel
`define COIN_COUNT      6           // nickel up to five dollar bill

`define ITEM_PRICE_0    100         // prices in cents
`define ITEM_PRICE_1    0           // zero price marks a sold out slot
`define ITEM_PRICE_2    125
`define ITEM_PRICE_3    175
`define ITEM_PRICE_4    225
`define ITEM_PRICE_5    250
`define ITEM_PRICE_6    100
`define ITEM_PRICE_7    325
`define ITEM_PRICE_8    375

`define COIN_VALUE_0    5           // coin values in cents
`define COIN_VALUE_1    10
`define COIN_VALUE_2    25
`define COIN_VALUE_3    50
`define COIN_VALUE_4    100
`define COIN_VALUE_5    500

`define MAX_CREDIT      500         // credit ceiling in cents
`define MONEY_BITS      9           // wide enough for the ceiling

`define DEBOUNCE_CYCLES 8           // equal samples before a level is taken
`define SCAN_DIV_BITS   3           // each digit lit for 2**n cycles

// seven segment patterns are active low with the decimal point in bit 0
`define SEG_DIGIT_0     8'b10000001
`define SEG_DIGIT_1     8'b11110011
`define SEG_DIGIT_2     8'b01001001
`define SEG_DIGIT_3     8'b01100001
`define SEG_DIGIT_4     8'b00110011
`define SEG_DIGIT_5     8'b00100101
`define SEG_DIGIT_6     8'b00000101
`define SEG_DIGIT_7     8'b11110001
`define SEG_DIGIT_8     8'b00000001
`define SEG_DIGIT_9     8'b00100001
`define SEG_MINUS       8'b01111111

`endif

// ==== project.f ====
+incdir+logic
logic/vendPkg.sv
logic/segPkg.sv
logic/keyBank.sv
logic/creditController.sv
logic/displayFormatter.sv
logic/displayScanner.sv
logic/vendingTop.sv
verification/vendingTb.sv

// ==== verification/vendingTb.sv ====
`include "vending_cfg.svh"

module vendingTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int holdCycles = `DEBOUNCE_CYCLES + 4;            // debouncer needs at most n+3
    localparam int scanLimit  = 4 * (2 ** (`SCAN_DIV_BITS + 2)); // four full scans

    localparam int priceOf [`ITEM_COUNT] = '{`ITEM_PRICE_0, `ITEM_PRICE_1, `ITEM_PRICE_2,
        `ITEM_PRICE_3, `ITEM_PRICE_4, `ITEM_PRICE_5, `ITEM_PRICE_6, `ITEM_PRICE_7,
        `ITEM_PRICE_8};
    localparam int coinOf [`COIN_COUNT] = '{`COIN_VALUE_0, `COIN_VALUE_1, `COIN_VALUE_2,
        `COIN_VALUE_3, `COIN_VALUE_4, `COIN_VALUE_5};
    localparam logic [7:0] glyphOf [10] = '{`SEG_DIGIT_0, `SEG_DIGIT_1, `SEG_DIGIT_2,
        `SEG_DIGIT_3, `SEG_DIGIT_4, `SEG_DIGIT_5, `SEG_DIGIT_6, `SEG_DIGIT_7,
        `SEG_DIGIT_8, `SEG_DIGIT_9};

    logic                   A1;
    logic                   A2;
    logic [`ITEM_COUNT-1:0] itemKey_n;
    logic [`COIN_COUNT-1:0] coinKey_n;
    logic                   cancelKey_n;
    logic [`ITEM_COUNT-1:0] ledGreen;
    logic [`ITEM_COUNT-1:0] ledRed;
    logic [`ITEM_COUNT-1:0] ledDispensed;
    logic [3:0]             anode;
    logic [7:0]             segments;

    int                     expCredit;              // reference model state
    int                     expMag;
    logic                   expNeg;
    logic [`ITEM_COUNT-1:0] expDispensed;
    logic [`ITEM_COUNT-1:0] expGreen;
    logic [`ITEM_COUNT-1:0] expRed;
    logic                   settled;                // lamps hold their final value
    logic                   refusedSeen;            // a coin hit the ceiling
    integer                 seed;
    int                     tries;

    vendingTop DUT (.*);

    initial A1 = 1'b0;
    always #2 A1 = ~A1;                             // 4 ns period

    always_comb begin
        for (int i = 0; i < `ITEM_COUNT; i++) begin
            expGreen[i] = priceOf[i] > 0 && expCredit >= priceOf[i];
            expRed[i]   = priceOf[i] == 0;          // sold out
        end
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // lamps compared every cycle once a press has settled
    lampCheck: assert property (@(posedge A1) disable iff (A2 || !settled)
        ledGreen == expGreen && ledRed == expRed && ledDispensed == expDispensed)
        else abortRun($sformatf("Mismatch at %0t ns: lamps g=%b r=%b d=%b, expected %b %b %b",
            $time, ledGreen, ledRed, ledDispensed, expGreen, expRed, expDispensed));

    function automatic int decodeDigit(input logic [7:0] pattern);
        int value;
        value = -1;                                 // not a digit
        for (int v = 0; v < 10; v++) begin
            if (pattern == glyphOf[v]) value = v;
        end
        return value;
    endfunction

    // priority is cancel then coins then items, lowest index first
    task automatic applyModel(input logic [`ITEM_COUNT-1:0] items,
                              input logic [`COIN_COUNT-1:0] coins, input logic cancel);
        int value;
        int slot;
        value = -1;
        slot  = -1;
        for (int i = `COIN_COUNT - 1; i >= 0; i--) if (coins[i]) value = coinOf[i];
        for (int i = `ITEM_COUNT - 1; i >= 0; i--) if (items[i]) slot = i;
        if (cancel) begin
            expCredit    = 0;
            expDispensed = '0;
            expMag       = 0;
            expNeg       = 1'b0;
        end else if (value >= 0) begin
            if (expCredit + value <= `MAX_CREDIT) begin
                expCredit = expCredit + value;
                expMag    = expCredit;
                expNeg    = 1'b0;
            end else begin
                refusedSeen = 1'b1;                 // refused coin changes nothing
            end
        end else if (slot >= 0) begin
            if (expCredit == 0) begin
                expMag = priceOf[slot];             // price query
                expNeg = 1'b0;
            end else if (priceOf[slot] > 0 && expCredit >= priceOf[slot]) begin
                expMag             = expCredit - priceOf[slot];
                expNeg             = 1'b0;
                expDispensed       = '0;
                expDispensed[slot] = 1'b1;
                expCredit          = 0;
            end else if (priceOf[slot] == 0) begin
                expMag = expCredit;                 // sold out shows credit as negative
                expNeg = 1'b1;
            end else begin
                expMag = priceOf[slot] - expCredit; // shortfall
                expNeg = 1'b1;
            end
        end
    endtask

    // collect one pattern per lit anode, then read back the amount
    task automatic checkDisplay();
        logic [7:0] seen [4];
        logic [3:0] got;
        int         waited;
        int         d2;
        int         d1;
        int         d0;
        logic       shownNeg;
        got    = '0;
        waited = 0;
        while (got != 4'hF) begin
            @(negedge A1);                          // outputs stable mid cycle
            for (int d = 0; d < 4; d++) begin
                if (anode == ~(4'b0001 << d)) begin
                    seen[d] = segments;
                    got[d]  = 1'b1;
                end
            end
            waited++;
            if (waited > scanLimit) abortRun("the display scan never lit all four digits");
        end
        shownNeg = seen[3] == `SEG_MINUS;
        d2 = decodeDigit(seen[2] | 8'h01);          // point removed before lookup
        d1 = decodeDigit(seen[1]);
        d0 = decodeDigit(seen[0]);
        assert (shownNeg || seen[3] == `SEG_DIGIT_0)
            else abortRun($sformatf("Mismatch at %0t ns: left digit %b", $time, seen[3]));
        assert (seen[2][0] == 1'b0 && d2 >= 0 && d1 >= 0 && d0 >= 0)
            else abortRun($sformatf("Mismatch at %0t ns: digits %b %b %b not readable",
                $time, seen[2], seen[1], seen[0]));
        assert (shownNeg == expNeg && d2 * 100 + d1 * 10 + d0 == expMag)
            else abortRun($sformatf("Mismatch at %0t ns: display %s%0d%0d%0d, expected %s%0d",
                $time, shownNeg ? "-" : "", d2, d1, d0, expNeg ? "-" : "", expMag));
    endtask

    // hold the keys low, release them, then check the settled result
    task automatic pressKeys(input logic [`ITEM_COUNT-1:0] items,
                             input logic [`COIN_COUNT-1:0] coins, input logic cancel);
        @(posedge A1);
        #1;
        settled     = 1'b0;
        applyModel(items, coins, cancel);
        itemKey_n   = ~items;
        coinKey_n   = ~coins;
        cancelKey_n = ~cancel;
        repeat (holdCycles) @(posedge A1);
        #1;
        itemKey_n   = '1;
        coinKey_n   = '1;
        cancelKey_n = 1'b1;
        repeat (holdCycles) @(posedge A1);
        #1;
        settled = 1'b1;
        checkDisplay();
    endtask

    task automatic pressItem(input int slot);
        logic [`ITEM_COUNT-1:0] mask;
        mask       = '0;
        mask[slot] = 1'b1;
        pressKeys(mask, '0, 1'b0);
    endtask

    task automatic pressCoin(input int kind);
        logic [`COIN_COUNT-1:0] mask;
        mask       = '0;
        mask[kind] = 1'b1;
        pressKeys('0, mask, 1'b0);
    endtask

    initial begin
        seed         = 32'h3660_88e7;
        A2           = 1'b1;
        itemKey_n    = '1;                          // buttons idle high
        coinKey_n    = '1;
        cancelKey_n  = 1'b1;
        settled      = 1'b0;
        expCredit    = 0;
        expMag       = 0;
        expNeg       = 1'b0;
        expDispensed = '0;
        refusedSeen  = 1'b0;
        repeat (2) @(posedge A1);
        #1;
        A2 = 1'b0;
        repeat (2) @(posedge A1);
        #1;
        settled = 1'b1;
        assert (ledGreen == '0 && ledDispensed == '0 && ledRed == expRed)
            else abortRun($sformatf("Mismatch at %0t ns: lamps after reset", $time));
        checkDisplay();                             // 0.00 out of reset

        for (int s = 0; s < `ITEM_COUNT; s++) pressItem(s);   // price queries

        repeat (8) pressCoin(($random(seed) & 32'h7FFF_FFFF) % `COIN_COUNT);
        tries = 0;
        while (!refusedSeen && tries < 8) begin    // push toward the ceiling
            pressCoin(4);
            tries++;
        end

        pressKeys('0, '0, 1'b1);
        pressCoin(2);                               // 0.25 credit
        pressItem(8);                               // shortfall
        pressItem(1);                               // sold out
        pressCoin(4);                               // credit kept so 1.25 now
        pressCoin(3);
        pressItem(0);                               // vend with 0.75 change
        pressItem(3);                               // price query keeps dispensed lamp

        pressCoin(4);
        pressKeys('0, '0, 1'b1);                    // plain cancel
        pressCoin(3);
        pressKeys('0, 6'b010000, 1'b1);             // cancel beats a coin

        $display("Verification passed");
        $finish;
    end

endmodule
